// File: include/hdr_params.svh
/* widths and sizes of the camera stream path; pixels per word times pixel width
   must equal the word width, and FIFO depth should stay a small power of two */
`ifndef HDR_PARAMS_SVH
`define HDR_PARAMS_SVH

// raw pixel and memory word
`define HDR_PIX_W        8
`define HDR_WORD_W       64
`define HDR_PIX_PER_WORD 8

// mode switch width
`define HDR_MODE_W       2

// output buffer and credit link
`define HDR_FIFO_DEPTH   4
`define HDR_LINK_CREDITS 4

`endif

// File: hw/hdr_pkg.sv
/* stream types shared by every stage; beats carry no handshake and the
   camera side can never be stalled */
`include "hdr_params.svh"

package hdr_pkg;

	// pixel source, 00 falls back to camera 0
	typedef enum logic [`HDR_MODE_W-1:0] {
		MODE_DEFAULT = 2'b00,
		MODE_CAM0    = 2'b01,
		MODE_CAM1    = 2'b10,
		MODE_HDR     = 2'b11
	} mode_e;

	// one aligned beat from both cameras
	typedef struct packed {
		logic                  valid;
		logic                  sof;
		logic                  eof;
		logic [`HDR_PIX_W-1:0] cam0;
		logic [`HDR_PIX_W-1:0] cam1;
	} cam_pair_t;

	// selected pixel after the mode mux
	typedef struct packed {
		logic                  valid;
		logic                  sof;
		logic                  eof;
		logic [`HDR_PIX_W-1:0] pix;
	} pix_beat_t;

	// memory word, first pixel in the low byte
	typedef struct packed {
		logic                   first;
		logic                   last;
		logic [`HDR_WORD_W-1:0] data;
	} mem_word_t;

endpackage

// File: hw/cam_input_sync.sv
/* cameras must already be in sys_clk_b and pixel aligned; the switch value
   is sampled only at sof, so a change mid frame waits for the next frame */
`timescale 1ns/1ns
`include "hdr_params.svh"

module cam_input_sync
	import hdr_pkg::*;
(
	input  logic                   sys_clk_b,
	input  logic                   reset_n_b,
	input  cam_pair_t              cam_i,
	input  logic [`HDR_MODE_W-1:0] mode_sw_i,
	output cam_pair_t              cam_o,
	output mode_e                  mode_o
);

	logic [`HDR_MODE_W-1:0] sw_meta;
	logic [`HDR_MODE_W-1:0] sw_sync;
	mode_e                  frame_mode;
	mode_e                  beat_mode;
	logic                   frame_start;

	assign frame_start = cam_i.valid & cam_i.sof;

	// the sof beat itself already uses the new mode
	assign beat_mode = frame_start ? mode_e'(sw_sync) : frame_mode;

	// two flop switch synchroniser and frame mode latch
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			sw_meta    <= '0;
			sw_sync    <= '0;
			frame_mode <= MODE_DEFAULT;
		end
		else
		begin
			sw_meta <= mode_sw_i;
			sw_sync <= sw_meta;
			if (frame_start)
				frame_mode <= beat_mode;
		end
	end

	// beat and its mode leave together
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			cam_o  <= '0;
			mode_o <= MODE_DEFAULT;
		end
		else
		begin
			cam_o  <= cam_i;
			mode_o <= beat_mode;
		end
	end

endmodule

// File: hw/hdr_mode_mux.sv
/* the HDR sample here is only the mean of the two pixels, rounded down;
   flags pass through unchanged with one cycle of latency */
`timescale 1ns/1ns
`include "hdr_params.svh"

module hdr_mode_mux
	import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	input  cam_pair_t cam_i,
	input  mode_e     mode_i,
	output pix_beat_t beat_o
);

	logic [`HDR_PIX_W:0]   fused_sum;
	logic [`HDR_PIX_W-1:0] fused_pix;
	logic [`HDR_PIX_W-1:0] sel_pix;

	// 9 bit sum, upper bits give the floor of the mean
	assign fused_sum = {1'b0, cam_i.cam0} + {1'b0, cam_i.cam1};
	assign fused_pix = fused_sum[`HDR_PIX_W:1];

	always_comb
	begin
		case (mode_i)
			MODE_CAM1: sel_pix = cam_i.cam1;
			MODE_HDR:  sel_pix = fused_pix;
			// MODE_DEFAULT behaves as camera 0
			default:   sel_pix = cam_i.cam0;
		endcase
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			beat_o <= '0;
		else
		begin
			beat_o.valid <= cam_i.valid;
			beat_o.sof   <= cam_i.sof;
			beat_o.eof   <= cam_i.eof;
			beat_o.pix   <= sel_pix;
		end
	end

endmodule

// File: hw/ddr_word_packer.sv
/* a word leaves one cycle after its last byte or eof; short words are zero
   padded at the top, and a sof on a partial word drops that partial word */
`timescale 1ns/1ns
`include "hdr_params.svh"

module ddr_word_packer
	import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	input  pix_beat_t beat_i,
	output mem_word_t word_o,
	output logic      word_valid_o
);

	localparam int PPW   = `HDR_PIX_PER_WORD;
	localparam int IDX_W = $clog2(PPW);

	logic [IDX_W-1:0]       byte_idx;
	logic [IDX_W-1:0]       cur_idx;
	logic [`HDR_WORD_W-1:0] shreg;
	logic [`HDR_WORD_W-1:0] next_shift;
	logic                   first_pend;
	logic                   word_done;
	int                     pad_bits;

	// sof always restarts at byte 0
	assign cur_idx = beat_i.sof ? '0 : byte_idx;

	// new pixel enters at the top, older ones move toward byte 0
	assign next_shift = {beat_i.pix, shreg[`HDR_WORD_W-1:`HDR_PIX_W]};

	assign word_done = beat_i.valid & (beat_i.eof | (cur_idx == IDX_W'(PPW - 1)));

	// unfilled bytes on eof, the shift pulls in zeros from the top
	assign pad_bits = (PPW - 1 - int'(cur_idx)) * `HDR_PIX_W;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			byte_idx     <= '0;
			first_pend   <= 1'b0;
			word_valid_o <= 1'b0;
		end
		else
		begin
			word_valid_o <= word_done;
			if (word_done)
			begin
				byte_idx   <= '0;
				first_pend <= 1'b0;
			end
			else if (beat_i.valid)
			begin
				byte_idx   <= cur_idx + 1'b1;
				first_pend <= first_pend | beat_i.sof;
			end
		end
	end

	always_ff @(posedge sys_clk_b)
	begin
		if (beat_i.valid)
			shreg <= next_shift;
		if (word_done)
		begin
			word_o.first <= first_pend | beat_i.sof;
			word_o.last  <= beat_i.eof;
			word_o.data  <= next_shift >> pad_bits;
		end
	end

endmodule

// File: hw/credit_tx_fifo.sv
/* sends only while credits remain; one credit_i pulse returns one credit and
   extra returns beyond the initial grant are ignored; overflow stays set until reset */
`timescale 1ns/1ns
`include "hdr_params.svh"

module credit_tx_fifo
	import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	input  mem_word_t word_i,
	input  logic      word_valid_i,
	input  logic      credit_i,
	output mem_word_t mem_o,
	output logic      mem_valid_o,
	output logic      overflow_o
);

	localparam int DEPTH   = `HDR_FIFO_DEPTH;
	localparam int CREDITS = `HDR_LINK_CREDITS;
	localparam int PTR_W   = $clog2(DEPTH);
	localparam int CNT_W   = $clog2(DEPTH + 1);
	localparam int CRD_W   = $clog2(CREDITS + 1);

	mem_word_t        fifo_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credit_cnt;
	mem_word_t        head;
	logic             fifo_empty;
	logic             fifo_full;
	logic             send;
	logic             bypass;
	logic             pop;
	logic             push;
	logic             drop;

	assign fifo_empty = (count == '0);
	assign fifo_full  = (count == CNT_W'(DEPTH));

	// an empty FIFO forwards the incoming word straight to the output
	assign head   = fifo_empty ? word_i : fifo_mem[rd_ptr];
	assign send   = (credit_cnt != '0) & (!fifo_empty | word_valid_i);
	assign bypass = send & fifo_empty;
	assign pop    = send & !fifo_empty;
	assign push   = word_valid_i & !bypass & (!fifo_full | pop);
	assign drop   = word_valid_i & !bypass & fifo_full & !pop;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			credit_cnt  <= CRD_W'(CREDITS);
			mem_valid_o <= 1'b0;
			overflow_o  <= 1'b0;
		end
		else
		begin
			mem_valid_o <= send;
			if (drop)
				overflow_o <= 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// send and return in one cycle cancel out
			case ({send, credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:
				begin
					if (credit_cnt != CRD_W'(CREDITS))
						credit_cnt <= credit_cnt + 1'b1;
				end
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// storage and output word
	always_ff @(posedge sys_clk_b)
	begin
		if (push)
			fifo_mem[wr_ptr] <= word_i;
		if (send)
			mem_o <= head;
	end

endmodule

// File: hw/hdr_stream_top.sv
/* camera pair in, packed memory words out on a credit link; a word appears
   4 cycles after the beat that completes it when credits are available */
`timescale 1ns/1ns
`include "hdr_params.svh"

module hdr_stream_top
	import hdr_pkg::*;
(
	input  logic                   sys_clk_b,
	input  logic                   reset_n_b,
	input  cam_pair_t              cam_i,
	input  logic [`HDR_MODE_W-1:0] mode_sw_i,
	input  logic                   credit_i,
	output mem_word_t              mem_o,
	output logic                   mem_valid_o,
	output logic                   overflow_o
);

	cam_pair_t cam_q;
	mode_e     mode_q;
	pix_beat_t beat;
	mem_word_t word;
	logic      word_valid;

	cam_input_sync cam_input_sync_inst
	(
		.sys_clk_b (sys_clk_b),
		.reset_n_b (reset_n_b),
		.cam_i     (cam_i),
		.mode_sw_i (mode_sw_i),
		.cam_o     (cam_q),
		.mode_o    (mode_q)
	);

	hdr_mode_mux hdr_mode_mux_inst
	(
		.sys_clk_b (sys_clk_b),
		.reset_n_b (reset_n_b),
		.cam_i     (cam_q),
		.mode_i    (mode_q),
		.beat_o    (beat)
	);

	ddr_word_packer ddr_word_packer_inst
	(
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.beat_i       (beat),
		.word_o       (word),
		.word_valid_o (word_valid)
	);

	credit_tx_fifo credit_tx_fifo_inst
	(
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.word_i       (word),
		.word_valid_i (word_valid),
		.credit_i     (credit_i),
		.mem_o        (mem_o),
		.mem_valid_o  (mem_valid_o),
		.overflow_o   (overflow_o)
	);

endmodule

// File: tests/hdr_stream_props.sv
/* credit link checks, bound to credit_tx_fifo; reads its internal credit
   counter, so the counter width must follow HDR_LINK_CREDITS */
`timescale 1ns/1ns
`include "hdr_params.svh"

module hdr_stream_props
(
	input logic                                    sys_clk_b,
	input logic                                    reset_n_b,
	input logic [$clog2(`HDR_LINK_CREDITS+1)-1:0] credit_cnt_i,
	input logic                                    mem_valid_i,
	input logic                                    overflow_i
);

	// a zero count must block the send in the following cycle
	no_send_without_credit: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		(credit_cnt_i == '0) |=> !mem_valid_i
	) else $error("word sent while no credit was left");

	credit_bound: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		credit_cnt_i <= `HDR_LINK_CREDITS
	) else $error("credit count above the initial grant");

	// outputs quiet in the first cycle out of reset
	reset_state: assert property (
		@(posedge sys_clk_b)
		$rose(reset_n_b) |-> (!mem_valid_i && !overflow_i)
	) else $error("valid or overflow high right after reset");

endmodule

// File: tests/hdr_stream_tb.sv
/* directed tests of the camera stream path; the sink returns one credit per
   received word, and overflow is sticky so the overflow test runs last */
`timescale 1ns/1ns
`include "hdr_params.svh"

module hdr_stream_tb
	import hdr_pkg::*;
();

	logic                   sys_clk_b;
	logic                   reset_n_b;
	cam_pair_t              cam_i;
	logic [`HDR_MODE_W-1:0] mode_sw_i;
	logic                   credit_i;
	mem_word_t              mem_o;
	logic                   mem_valid_o;
	logic                   overflow_o;

	mem_word_t             exp_q[$];
	int                    due_q[$];
	logic [`HDR_PIX_W-1:0] pix0 [64];
	logic [`HDR_PIX_W-1:0] pix1 [64];
	logic                  hold_credits;
	int                    credit_delay;
	int                    extra_credits = 0;
	int                    cycle_cnt = 0;
	int                    rx_count = 0;
	int                    chk_count = 0;
	int                    err_count = 0;
	int                    timeout_count = 0;

	hdr_stream_top hdr_stream_top_inst
	(
		.sys_clk_b   (sys_clk_b),
		.reset_n_b   (reset_n_b),
		.cam_i       (cam_i),
		.mode_sw_i   (mode_sw_i),
		.credit_i    (credit_i),
		.mem_o       (mem_o),
		.mem_valid_o (mem_valid_o),
		.overflow_o  (overflow_o)
	);

	bind credit_tx_fifo hdr_stream_props hdr_stream_props_inst
	(
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.credit_cnt_i (credit_cnt),
		.mem_valid_i  (mem_valid_o),
		.overflow_i   (overflow_o)
	);

	initial
	begin
		sys_clk_b = 1'b0;
		forever
			#5 sys_clk_b = ~sys_clk_b;
	end

	task automatic tick();
		@(posedge sys_clk_b);
		#1;
	endtask

	task automatic compare_word(input string name, input mem_word_t got, input mem_word_t exp);
		chk_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		chk_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		chk_count++;
		if (got != exp)
		begin
			err_count++;
			$display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
		end
	endtask

	// model of the pixel source for one beat
	function automatic logic [`HDR_PIX_W-1:0] expect_pix(input mode_e m,
		input logic [`HDR_PIX_W-1:0] a, input logic [`HDR_PIX_W-1:0] b);
		int s;
		s = int'(a) + int'(b);
		case (m)
			MODE_CAM1: return b;
			MODE_HDR:  return 8'(s / 2);
			default:   return a;
		endcase
	endfunction

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
		begin
			pix0[i] = 8'($urandom);
			pix1[i] = 8'($urandom);
		end
	endtask

	// eight pixels per word with the first pixel in the low byte and a zero padded tail
	task automatic queue_frame(input int n, input mode_e m);
		mem_word_t w;
		int        k;
		w = '0;
		for (int i = 0; i < n; i++)
		begin
			k = i % `HDR_PIX_PER_WORD;
			if (k == 0)
			begin
				w = '0;
				w.first = (i == 0);
			end
			w.data[k*`HDR_PIX_W +: `HDR_PIX_W] = expect_pix(m, pix0[i], pix1[i]);
			if (k == `HDR_PIX_PER_WORD - 1 || i == n - 1)
			begin
				w.last = (i == n - 1);
				exp_q.push_back(w);
			end
		end
	endtask

	task automatic send_frame(input int n, input mode_e m, input int chg_at, input mode_e chg_sw);
		mode_sw_i = m;
		// switch has to clear the synchroniser before sof
		repeat (3) tick();
		queue_frame(n, m);
		for (int i = 0; i < n; i++)
		begin
			cam_i.valid = 1'b1;
			cam_i.sof   = (i == 0);
			cam_i.eof   = (i == n - 1);
			cam_i.cam0  = pix0[i];
			cam_i.cam1  = pix1[i];
			if (i == chg_at)
				mode_sw_i = chg_sw;
			tick();
		end
		cam_i = '0;
	endtask

	task automatic wait_rx(input int target, input string what);
		int cycles;
		cycles = 0;
		while (rx_count < target && cycles < 400)
		begin
			tick();
			cycles++;
		end
		if (rx_count < target)
		begin
			timeout_count++;
			$display("timeout at %0t while waiting for %s", $time, what);
		end
	endtask

	// all expected words seen and all credits handed back
	task automatic wait_drain(input string what);
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || due_q.size() != 0) && cycles < 400)
		begin
			tick();
			cycles++;
		end
		if (exp_q.size() != 0 || due_q.size() != 0)
		begin
			timeout_count++;
			$display("timeout at %0t while waiting for %s", $time, what);
		end
	endtask

	task automatic test_cam0_default();
		fill_random(8);
		send_frame(8, MODE_CAM0, -1, MODE_CAM0);
		wait_drain("camera 0 frame");
		fill_random(8);
		send_frame(8, MODE_DEFAULT, -1, MODE_DEFAULT);
		wait_drain("default mode frame");
	endtask

	task automatic test_cam1_hdr();
		fill_random(8);
		send_frame(8, MODE_CAM1, -1, MODE_CAM1);
		wait_drain("camera 1 frame");
		fill_random(8);
		pix0[0] = 8'd255;
		pix1[0] = 8'd255;
		pix0[1] = 8'd0;
		pix1[1] = 8'd255;
		pix0[2] = 8'd255;
		pix1[2] = 8'd0;
		send_frame(8, MODE_HDR, -1, MODE_HDR);
		wait_drain("fused frame");
	endtask

	task automatic test_mid_frame_switch();
		fill_random(16);
		send_frame(16, MODE_CAM1, 4, MODE_HDR);
		wait_drain("frame with switch change");
		fill_random(16);
		send_frame(16, MODE_HDR, -1, MODE_HDR);
		wait_drain("frame after switch change");
	endtask

	task automatic test_short_word();
		credit_delay = 5;
		fill_random(13);
		send_frame(13, MODE_CAM0, -1, MODE_CAM0);
		wait_drain("13 pixel frame");
		credit_delay = 2;
	endtask

	task automatic test_credit_hold();
		int cycles;
		// surplus returns while the link holds its full grant add no credits
		extra_credits = 2;
		cycles = 0;
		while (extra_credits != 0 && cycles < 20)
		begin
			tick();
			cycles++;
		end
		if (extra_credits != 0)
		begin
			timeout_count++;
			$display("timeout at %0t while returning surplus credits", $time);
		end
		hold_credits = 1'b1;
		rx_count = 0;
		for (int f = 0; f < `HDR_LINK_CREDITS + `HDR_FIFO_DEPTH; f++)
		begin
			fill_random(8);
			send_frame(8, MODE_HDR, -1, MODE_HDR);
		end
		wait_rx(`HDR_LINK_CREDITS, "words on the initial credits");
		repeat (20) tick();
		compare_count("rx_count", rx_count, `HDR_LINK_CREDITS);
		hold_credits = 1'b0;
		wait_drain("words held in the FIFO");
		compare_count("rx_count", rx_count, `HDR_LINK_CREDITS + `HDR_FIFO_DEPTH);
		compare_flag("overflow_o", overflow_o, 1'b0);
	endtask

	task automatic test_overflow();
		hold_credits = 1'b1;
		rx_count = 0;
		for (int f = 0; f < `HDR_LINK_CREDITS + `HDR_FIFO_DEPTH + 2; f++)
		begin
			fill_random(8);
			send_frame(8, MODE_CAM1, -1, MODE_CAM1);
		end
		wait_rx(`HDR_LINK_CREDITS, "words on the initial credits");
		repeat (20) tick();
		compare_count("rx_count", rx_count, `HDR_LINK_CREDITS);
		compare_flag("overflow_o", overflow_o, 1'b1);
		hold_credits = 1'b0;
		wait_rx(`HDR_LINK_CREDITS + `HDR_FIFO_DEPTH, "words left in the FIFO");
		repeat (20) tick();
		compare_count("rx_count", rx_count, `HDR_LINK_CREDITS + `HDR_FIFO_DEPTH);
		// the two newest words were dropped at the full FIFO
		compare_count("exp_q.size", exp_q.size(), 2);
		exp_q.delete();
		compare_flag("overflow_o", overflow_o, 1'b1);
	endtask

	// the sink samples the registered outputs away from the rising edge
	initial
	begin
		forever
		begin
			@(negedge sys_clk_b);
			if (reset_n_b && mem_valid_o)
			begin
				rx_count++;
				due_q.push_back(cycle_cnt + credit_delay);
				if (exp_q.size() == 0)
				begin
					err_count++;
					$display("unexpected word on mem_o at %0t with none expected", $time);
				end
				else
					compare_word("mem_o", mem_o, exp_q.pop_front());
			end
		end
	end

	// one credit pulse per consumed word once its delay is over
	initial
	begin
		credit_i = 1'b0;
		forever
		begin
			tick();
			cycle_cnt++;
			credit_i = 1'b0;
			if (extra_credits != 0)
			begin
				credit_i = 1'b1;
				extra_credits--;
			end
			else if (!hold_credits && due_q.size() != 0 && cycle_cnt >= due_q[0])
			begin
				credit_i = 1'b1;
				void'(due_q.pop_front());
			end
		end
	end

	initial
	begin
		void'($urandom(32'hd17d2a91));
		reset_n_b    = 1'b0;
		cam_i        = '0;
		mode_sw_i    = '0;
		hold_credits = 1'b0;
		credit_delay = 2;
		repeat (5) tick();
		reset_n_b = 1'b1;
		tick();
		compare_flag("mem_valid_o", mem_valid_o, 1'b0);
		compare_flag("overflow_o", overflow_o, 1'b0);
		test_cam0_default();
		test_cam1_hdr();
		test_mid_frame_switch();
		test_short_word();
		test_credit_hold();
		test_overflow();
		$display("checks %0d, errors %0d, timeouts %0d", chk_count, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+include
hw/hdr_pkg.sv
hw/cam_input_sync.sv
hw/hdr_mode_mux.sv
hw/ddr_word_packer.sv
hw/credit_tx_fifo.sv
hw/hdr_stream_top.sv
tests/hdr_stream_props.sv
tests/hdr_stream_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = hdr_stream_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
